// File: verilog/bridge_macros.svh
`ifndef BRIDGE_MACROS_SVH
`define BRIDGE_MACROS_SVH

// host line framing
`define BRIDGE_FRAME_BITS 16        // cmd byte + data byte, start bit not counted
`define BRIDGE_REPLY_BITS 18        // start + 16 data + stop

// memory side
`define BRIDGE_NUM_CHANNELS 2
`define BRIDGE_ADDR_BITS 24
`define BRIDGE_DATA_BITS 16

// command groups (high nibble)
`define BRIDGE_GRP_REG 4'h1         // staging register loads
`define BRIDGE_GRP_CH0 4'hA         // channel 0 word access
`define BRIDGE_GRP_CH1 4'hB         // channel 1 word access

// channel ops (low nibble)
`define BRIDGE_OP_WRITE 4'h0
`define BRIDGE_OP_READ 4'h1

// staging register selects (low nibble)
`define BRIDGE_REG_DATA0 4'h0
`define BRIDGE_REG_DATA1 4'h1
`define BRIDGE_REG_ADDR0 4'h2
`define BRIDGE_REG_ADDR1 4'h3
`define BRIDGE_REG_ADDR2 4'h4

`endif

// File: verilog/bridge_pkg.sv
`include "bridge_macros.svh"

package bridge_pkg;

  typedef struct packed {
    logic [3:0] grp;                      // command group
    logic [3:0] op;                       // op within group
  } cmd_fields_t;

  // command byte, whole or split into nibbles
  typedef union packed {
    logic [7:0]  raw;
    cmd_fields_t f;
  } cmd_u;

  typedef struct packed {
    logic                         start;  // one-cycle pulse
    logic                         write;
    logic [`BRIDGE_ADDR_BITS-1:0] addr;
    logic [`BRIDGE_DATA_BITS-1:0] wdata;
  } ch_cmd_t;

  typedef struct packed {
    logic                         done;   // one-cycle pulse
    logic                         read;   // completion was a read
    logic [`BRIDGE_DATA_BITS-1:0] rdata;
  } ch_done_t;

  typedef struct packed {
    logic                         req;    // level, held until ack
    logic                         write;
    logic [`BRIDGE_ADDR_BITS-1:0] addr;
    logic [`BRIDGE_DATA_BITS-1:0] wdata;
  } mem_req_t;

  typedef struct packed {
    logic                         ack;    // one-cycle pulse
    logic [`BRIDGE_DATA_BITS-1:0] rdata;
  } mem_rsp_t;

endpackage

// File: verilog/serial_link.sv
`timescale 1ns/10ps
`include "bridge_macros.svh"

module serial_link (
  input  logic                         sys_clk,
  input  logic                         sys_rst_n,
  input  logic                         cy_a0_int0,
  input  logic                         cy_a3_wu2,
  output logic                         cy_a1_int1,
  output logic                         frame_valid,
  output bridge_pkg::cmd_u             frame_cmd,
  output logic [7:0]                   frame_data,
  input  logic                         frame_taken,
  input  logic                         reply_valid,
  input  logic [`BRIDGE_DATA_BITS-1:0] reply_data,
  output logic                         reply_taken
);

  logic [1:0]                   strb_sync;   // strobe synchronizer
  logic [1:0]                   din_sync;    // data line, same delay as strobe
  logic                         strb_last;
  logic                         strobe;      // one cycle per rising strobe
  logic                         rx_bit;

  logic                         rx_active;
  logic [4:0]                   rx_cnt;
  logic [`BRIDGE_FRAME_BITS-1:0] rx_shift;

  logic                         tx_active;
  logic [4:0]                   tx_cnt;
  logic [`BRIDGE_DATA_BITS-1:0] tx_shift;

  always_ff @(posedge sys_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      strb_sync <= '0;
      din_sync  <= '0;
      strb_last <= 1'b0;
    end else begin
      strb_sync <= {strb_sync[0], cy_a3_wu2};
      din_sync  <= {din_sync[0], cy_a0_int0};
      strb_last <= strb_sync[1];
    end
  end

  assign strobe = strb_sync[1] & ~strb_last;
  assign rx_bit = din_sync[1];

  // receive: start bit of 1, then 16 bits LSB first
  always_ff @(posedge sys_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      rx_active   <= 1'b0;
      rx_cnt      <= '0;
      frame_valid <= 1'b0;
    end else begin
      if (frame_taken) begin
        frame_valid <= 1'b0;
      end
      if (strobe) begin
        if (rx_active) begin
          rx_cnt <= rx_cnt + 5'd1;
          if (rx_cnt == 5'(`BRIDGE_FRAME_BITS - 1)) begin
            rx_active   <= 1'b0;
            frame_valid <= 1'b1;   // held until decoder takes it
          end
        end else if (rx_bit && !frame_valid) begin
          rx_active <= 1'b1;       // start bit, ignored while a frame waits
          rx_cnt    <= '0;
        end
      end
    end
  end

  always_ff @(posedge sys_clk) begin
    if (strobe && rx_active) begin
      rx_shift <= {rx_bit, rx_shift[`BRIDGE_FRAME_BITS-1:1]};   // first bit ends at bit 0
    end
  end

  assign frame_cmd  = rx_shift[7:0];
  assign frame_data = rx_shift[15:8];

  // transmit: 1, low byte, high byte, 0
  always_ff @(posedge sys_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      tx_active   <= 1'b0;
      tx_cnt      <= '0;
      cy_a1_int1  <= 1'b0;
      reply_taken <= 1'b0;
    end else begin
      reply_taken <= 1'b0;
      if (strobe) begin
        if (tx_active) begin
          tx_cnt <= tx_cnt + 5'd1;
          if (tx_cnt == 5'(`BRIDGE_REPLY_BITS - 1)) begin
            cy_a1_int1  <= 1'b0;   // stop bit
            tx_active   <= 1'b0;
            reply_taken <= 1'b1;
          end else begin
            cy_a1_int1 <= tx_shift[0];
          end
        end else if (reply_valid) begin
          cy_a1_int1 <= 1'b1;      // start bit
          tx_active  <= 1'b1;
          tx_cnt     <= 5'd1;
        end
      end
    end
  end

  always_ff @(posedge sys_clk) begin
    if (strobe) begin
      if (!tx_active) begin
        tx_shift <= reply_data;    // loaded on the start-bit strobe
      end else begin
        tx_shift <= tx_shift >> 1;
      end
    end
  end

endmodule

// File: verilog/cmd_decoder.sv
`timescale 1ns/10ps
`include "bridge_macros.svh"

module cmd_decoder (
  input  logic                sys_clk,
  input  logic                sys_rst_n,
  input  logic                frame_valid,
  input  bridge_pkg::cmd_u    frame_cmd,
  input  logic [7:0]          frame_data,
  output logic                frame_taken,
  output bridge_pkg::ch_cmd_t ch_cmd [0:`BRIDGE_NUM_CHANNELS-1],
  input  logic                cmd_done,
  output logic                busy
);

  logic [7:0]                      data0;
  logic [7:0]                      data1;
  logic [7:0]                      addr0;
  logic [7:0]                      addr1;
  logic [7:0]                      addr2;
  logic                            wait_ch;    // channel op outstanding
  logic [`BRIDGE_NUM_CHANNELS-1:0] ch_start;
  logic                            ch_write;
  logic [`BRIDGE_ADDR_BITS-1:0]    ch_addr;
  logic [`BRIDGE_DATA_BITS-1:0]    ch_wdata;
  logic                            known;
  logic                            is_ch;
  logic [3:0]                      ch_idx;

  assign frame_taken = frame_valid & ~busy;

  // whole-byte check, anything else is a no-op
  always_comb begin
    case (frame_cmd.raw)
      {`BRIDGE_GRP_REG, `BRIDGE_REG_DATA0},
      {`BRIDGE_GRP_REG, `BRIDGE_REG_DATA1},
      {`BRIDGE_GRP_REG, `BRIDGE_REG_ADDR0},
      {`BRIDGE_GRP_REG, `BRIDGE_REG_ADDR1},
      {`BRIDGE_GRP_REG, `BRIDGE_REG_ADDR2},
      {`BRIDGE_GRP_CH0, `BRIDGE_OP_WRITE},
      {`BRIDGE_GRP_CH0, `BRIDGE_OP_READ},
      {`BRIDGE_GRP_CH1, `BRIDGE_OP_WRITE},
      {`BRIDGE_GRP_CH1, `BRIDGE_OP_READ}: known = 1'b1;
      default:                            known = 1'b0;
    endcase
  end

  assign is_ch  = known && (frame_cmd.f.grp != `BRIDGE_GRP_REG);
  assign ch_idx = frame_cmd.f.grp - `BRIDGE_GRP_CH0;   // 0xA -> 0, 0xB -> 1

  always_ff @(posedge sys_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      busy     <= 1'b0;
      wait_ch  <= 1'b0;
      ch_start <= '0;
      data0    <= '0;
      data1    <= '0;
      addr0    <= '0;
      addr1    <= '0;
      addr2    <= '0;
    end else begin
      ch_start <= '0;
      if (frame_taken) begin
        busy <= 1'b1;
        if (is_ch) begin
          wait_ch <= 1'b1;
          for (int i = 0; i < `BRIDGE_NUM_CHANNELS; i++) begin
            ch_start[i] <= (ch_idx == 4'(i));   // addressed channel only
          end
        end else if (known) begin
          case (frame_cmd.f.op)
            `BRIDGE_REG_DATA0: data0 <= frame_data;
            `BRIDGE_REG_DATA1: data1 <= frame_data;
            `BRIDGE_REG_ADDR0: addr0 <= frame_data;
            `BRIDGE_REG_ADDR1: addr1 <= frame_data;
            `BRIDGE_REG_ADDR2: addr2 <= frame_data;
            default: ;
          endcase
        end
      end else if (busy && (!wait_ch || cmd_done)) begin
        busy    <= 1'b0;    // loads and no-ops drop after one cycle
        wait_ch <= 1'b0;
      end
    end
  end

  always_ff @(posedge sys_clk) begin
    if (frame_taken && is_ch) begin
      ch_write <= (frame_cmd.f.op == `BRIDGE_OP_WRITE);
      ch_addr  <= {addr2, addr1, addr0};
      ch_wdata <= {data1, data0};
    end
  end

  always_comb begin
    for (int i = 0; i < `BRIDGE_NUM_CHANNELS; i++) begin
      ch_cmd[i].start = ch_start[i];
      ch_cmd[i].write = ch_write;
      ch_cmd[i].addr  = ch_addr;
      ch_cmd[i].wdata = ch_wdata;
    end
  end

endmodule

// File: verilog/mem_channel.sv
`timescale 1ns/10ps
`include "bridge_macros.svh"

module mem_channel (
  input  logic                 sys_clk,
  input  logic                 sys_rst_n,
  input  bridge_pkg::ch_cmd_t  ch_cmd,
  output bridge_pkg::mem_req_t mem_req,
  input  bridge_pkg::mem_rsp_t mem_rsp,
  output bridge_pkg::ch_done_t ch_done
);

  logic                         req_q;
  logic                         done_q;
  logic                         write_q;
  logic [`BRIDGE_ADDR_BITS-1:0] addr_q;
  logic [`BRIDGE_DATA_BITS-1:0] wdata_q;
  logic [`BRIDGE_DATA_BITS-1:0] rdata_q;
  logic                         ack_seen;

  assign ack_seen = req_q & mem_rsp.ack;   // ack only counts while requesting

  always_ff @(posedge sys_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      req_q  <= 1'b0;
      done_q <= 1'b0;
    end else begin
      done_q <= 1'b0;
      if (ack_seen) begin
        req_q  <= 1'b0;
        done_q <= 1'b1;      // same cycle req drops
      end else if (ch_cmd.start && !req_q) begin
        req_q <= 1'b1;
      end
    end
  end

  // request fields stay put while req is high
  always_ff @(posedge sys_clk) begin
    if (ch_cmd.start && !req_q) begin
      write_q <= ch_cmd.write;
      addr_q  <= ch_cmd.addr;
      wdata_q <= ch_cmd.wdata;
    end
    if (ack_seen) begin
      rdata_q <= mem_rsp.rdata;
    end
  end

  assign mem_req.req   = req_q;
  assign mem_req.write = write_q;
  assign mem_req.addr  = addr_q;
  assign mem_req.wdata = wdata_q;

  assign ch_done.done  = done_q;
  assign ch_done.read  = ~write_q;
  assign ch_done.rdata = rdata_q;

endmodule

// File: verilog/reply_collector.sv
`timescale 1ns/10ps
`include "bridge_macros.svh"

module reply_collector (
  input  logic                         sys_clk,
  input  logic                         sys_rst_n,
  input  bridge_pkg::ch_done_t         ch_done [0:`BRIDGE_NUM_CHANNELS-1],
  output logic                         cmd_done,
  output logic                         reply_valid,
  output logic [`BRIDGE_DATA_BITS-1:0] reply_data,
  input  logic                         reply_taken
);

  logic                         any_read;
  logic [`BRIDGE_DATA_BITS-1:0] read_word;

  // merge completions, highest channel wins on a read
  always_comb begin
    cmd_done  = 1'b0;
    any_read  = 1'b0;
    read_word = '0;
    for (int i = 0; i < `BRIDGE_NUM_CHANNELS; i++) begin
      if (ch_done[i].done) begin
        cmd_done = 1'b1;
        if (ch_done[i].read) begin
          any_read  = 1'b1;
          read_word = ch_done[i].rdata;
        end
      end
    end
  end

  always_ff @(posedge sys_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      reply_valid <= 1'b0;
    end else if (any_read) begin
      reply_valid <= 1'b1;
    end else if (reply_taken) begin
      reply_valid <= 1'b0;   // frame fully sent
    end
  end

  always_ff @(posedge sys_clk) begin
    if (any_read) begin
      reply_data <= read_word;
    end
  end

endmodule

// File: verilog/usb_bridge_top.sv
`timescale 1ns/10ps
`include "bridge_macros.svh"

module usb_bridge_top (
  input  logic                 sys_clk,
  input  logic                 sys_rst_n,
  input  logic                 cy_a0_int0,
  input  logic                 cy_a3_wu2,
  output logic                 cy_a1_int1,
  output bridge_pkg::mem_req_t mem_req [0:`BRIDGE_NUM_CHANNELS-1],
  input  bridge_pkg::mem_rsp_t mem_rsp [0:`BRIDGE_NUM_CHANNELS-1],
  output logic                 busy
);

  logic                         frame_valid;
  bridge_pkg::cmd_u             frame_cmd;
  logic [7:0]                   frame_data;
  logic                         frame_taken;
  logic                         reply_valid;
  logic [`BRIDGE_DATA_BITS-1:0] reply_data;
  logic                         reply_taken;
  logic                         cmd_done;
  bridge_pkg::ch_cmd_t          ch_cmd  [0:`BRIDGE_NUM_CHANNELS-1];
  bridge_pkg::ch_done_t         ch_done [0:`BRIDGE_NUM_CHANNELS-1];

  serial_link u_serial_link (
    .sys_clk     (sys_clk),
    .sys_rst_n   (sys_rst_n),
    .cy_a0_int0  (cy_a0_int0),
    .cy_a3_wu2   (cy_a3_wu2),
    .cy_a1_int1  (cy_a1_int1),
    .frame_valid (frame_valid),
    .frame_cmd   (frame_cmd),
    .frame_data  (frame_data),
    .frame_taken (frame_taken),
    .reply_valid (reply_valid),
    .reply_data  (reply_data),
    .reply_taken (reply_taken)
  );

  cmd_decoder u_cmd_decoder (
    .sys_clk     (sys_clk),
    .sys_rst_n   (sys_rst_n),
    .frame_valid (frame_valid),
    .frame_cmd   (frame_cmd),
    .frame_data  (frame_data),
    .frame_taken (frame_taken),
    .ch_cmd      (ch_cmd),
    .cmd_done    (cmd_done),
    .busy        (busy)
  );

  // one sequencer per memory port
  for (genvar i = 0; i < `BRIDGE_NUM_CHANNELS; i++) begin : g_channel
    mem_channel u_mem_channel (
      .sys_clk   (sys_clk),
      .sys_rst_n (sys_rst_n),
      .ch_cmd    (ch_cmd[i]),
      .mem_req   (mem_req[i]),
      .mem_rsp   (mem_rsp[i]),
      .ch_done   (ch_done[i])
    );
  end

  reply_collector u_reply_collector (
    .sys_clk     (sys_clk),
    .sys_rst_n   (sys_rst_n),
    .ch_done     (ch_done),
    .cmd_done    (cmd_done),
    .reply_valid (reply_valid),
    .reply_data  (reply_data),
    .reply_taken (reply_taken)
  );

endmodule

// File: verification/tb_clock_gen.sv
`timescale 1ns/10ps

module tb_clock_gen #(
  parameter int PERIOD       = 8,
  parameter int RESET_CYCLES = 4
) (
  output logic sys_clk,
  output logic sys_rst_n
);

  initial begin
    sys_clk = 1'b0;
    forever #(PERIOD / 2) sys_clk = ~sys_clk;
  end

  initial begin
    sys_rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge sys_clk);
    @(negedge sys_clk);
    sys_rst_n = 1'b1;   // released on a falling edge
  end

endmodule

// File: verification/bridge_asserts.sv
`timescale 1ns/10ps
`include "bridge_macros.svh"

module bridge_asserts (
  input logic                 sys_clk,
  input logic                 sys_rst_n,
  input bridge_pkg::mem_req_t mem_req [0:`BRIDGE_NUM_CHANNELS-1],
  input bridge_pkg::mem_rsp_t mem_rsp [0:`BRIDGE_NUM_CHANNELS-1],
  input logic                 busy
);

  logic [`BRIDGE_NUM_CHANNELS-1:0] req_vec;

  always_comb begin
    for (int i = 0; i < `BRIDGE_NUM_CHANNELS; i++) begin
      req_vec[i] = mem_req[i].req;
    end
  end

  for (genvar i = 0; i < `BRIDGE_NUM_CHANNELS; i++) begin : g_stable
    // req and fields frozen until ack
    a_req_stable: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
      mem_req[i].req && !mem_rsp[i].ack |=> $stable(mem_req[i]))
      else $error("mem_req[%0d] changed while waiting for ack", i);
  end

  a_one_req: assert property (@(posedge sys_clk) disable iff (!sys_rst_n) $onehot0(req_vec))
    else $error("more than one channel requesting");

  a_idle_after_reset: assert property (@(posedge sys_clk) $rose(sys_rst_n) |-> !busy)
    else $error("busy high in the first cycle after reset");

endmodule

bind usb_bridge_top bridge_asserts u_bridge_asserts (
  .sys_clk   (sys_clk),
  .sys_rst_n (sys_rst_n),
  .mem_req   (mem_req),
  .mem_rsp   (mem_rsp),
  .busy      (busy)
);

// File: verification/bridge_tb.sv
`timescale 1ns/10ps
`include "bridge_macros.svh"

module bridge_tb;

  localparam int NUM_CMDS      = 60;
  localparam int STROBE_PERIOD = 8;   // sys_clk cycles per strobe period
  localparam int CYCLE_LIMIT   = NUM_CMDS * (40 * STROBE_PERIOD + 20);

  logic                 sys_clk;
  logic                 sys_rst_n;
  logic                 cy_a0_int0;
  logic                 cy_a3_wu2;
  logic                 cy_a1_int1;
  logic                 busy;
  bridge_pkg::mem_req_t mem_req [0:`BRIDGE_NUM_CHANNELS-1];
  bridge_pkg::mem_rsp_t mem_rsp [0:`BRIDGE_NUM_CHANNELS-1];

  logic [15:0] lfsr_state = 16'h0001;
  logic [15:0] mem_model [logic [24:0]];   // key is {channel, address}
  logic [7:0]  stage [0:4];                // data0, data1, addr0, addr1, addr2
  int          cycle_cnt = 0;

  tb_clock_gen #(.PERIOD(8), .RESET_CYCLES(4)) u_clock_gen (
    .sys_clk   (sys_clk),
    .sys_rst_n (sys_rst_n)
  );

  usb_bridge_top u_dut (
    .sys_clk    (sys_clk),
    .sys_rst_n  (sys_rst_n),
    .cy_a0_int0 (cy_a0_int0),
    .cy_a3_wu2  (cy_a3_wu2),
    .cy_a1_int1 (cy_a1_int1),
    .mem_req    (mem_req),
    .mem_rsp    (mem_rsp),
    .busy       (busy)
  );

  // 16-bit Fibonacci LFSR, taps 16 14 13 11
  function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
    lfsr_state = {lfsr_state[14:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_bit()};
    end
    return v;
  endfunction

  function automatic logic is_known(input logic [7:0] raw);
    return (raw[7:4] == `BRIDGE_GRP_REG && raw[3:0] <= `BRIDGE_REG_ADDR2) ||
           ((raw[7:4] == `BRIDGE_GRP_CH0 || raw[7:4] == `BRIDGE_GRP_CH1) &&
            raw[3:0] <= `BRIDGE_OP_READ);
  endfunction

  task automatic stop_run();
    $display("TEST FAILED");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("[ERROR] %0t %s: got 0x%0h, expected 0x%0h", $time, name, actual, expected);
      stop_run();
    end
  endtask

  // data set with strobe low, each strobe level held 4 cycles
  task automatic strobe_bit(input logic b);
    @(negedge sys_clk);
    cy_a0_int0 = b;
    cy_a3_wu2  = 1'b0;
    repeat (4) @(negedge sys_clk);
    cy_a3_wu2 = 1'b1;
    repeat (3) @(negedge sys_clk);
  endtask

  task automatic send_frame(input logic [7:0] cmd, input logic [7:0] data);
    logic [15:0] bits;
    bits = {data, cmd};   // cmd goes first, LSB first
    strobe_bit(1'b1);
    for (int i = 0; i < `BRIDGE_FRAME_BITS; i++) begin
      strobe_bit(bits[i]);
    end
  endtask

  task automatic wait_busy(input logic level);
    int n;
    n = 0;
    while (busy !== level) begin
      if (n == 40) begin
        $display("busy did not go to %0b within 40 cycles", level);
        stop_run();
      end else begin
        n++;
        @(negedge sys_clk);
      end
    end
  endtask

  // data line held low, one reply bit read after each strobe
  task automatic read_line(output logic [17:0] bits);
    for (int k = 0; k < `BRIDGE_REPLY_BITS; k++) begin
      strobe_bit(1'b0);
      bits[k] = cy_a1_int1;
      for (int c = 0; c < `BRIDGE_NUM_CHANNELS; c++) begin
        check_value($sformatf("mem_req[%0d].req", c), 32'(mem_req[c].req), 32'(0));
      end
    end
  endtask

  task automatic load_stage(input logic [2:0] sel, input logic [7:0] value);
    bridge_pkg::cmd_u cmd;
    cmd.f.grp = `BRIDGE_GRP_REG;
    cmd.f.op  = {1'b0, sel};   // DATA0..ADDR2 select 0..4
    send_frame(cmd.raw, value);
    wait_busy(1'b1);
    wait_busy(1'b0);
    stage[sel] = value;
  endtask

  // word access plus the memory model answering it
  task automatic mem_access(input logic ch, input logic write);
    bridge_pkg::cmd_u cmd;
    logic [24:0]      key;
    logic [15:0]      word;
    logic [17:0]      bits;
    int               n;
    cmd.f.grp = ch ? `BRIDGE_GRP_CH1 : `BRIDGE_GRP_CH0;
    cmd.f.op  = write ? `BRIDGE_OP_WRITE : `BRIDGE_OP_READ;
    key = {ch, stage[4], stage[3], stage[2]};
    send_frame(cmd.raw, 8'(rand_bits(8)));
    wait_busy(1'b1);
    n = 0;
    while (mem_req[ch].req !== 1'b1) begin
      if (n == 20) begin
        $display("no memory request on channel %0d", ch);
        stop_run();
      end else begin
        n++;
        @(negedge sys_clk);
      end
    end
    for (int c = 0; c < `BRIDGE_NUM_CHANNELS; c++) begin
      check_value($sformatf("mem_req[%0d].req", c), 32'(mem_req[c].req), 32'(c == ch));
    end
    check_value("mem_req.write", 32'(mem_req[ch].write), 32'(write));
    check_value("mem_req.addr", 32'(mem_req[ch].addr), 32'(key[23:0]));
    if (write) begin
      check_value("mem_req.wdata", 32'(mem_req[ch].wdata), 32'({stage[1], stage[0]}));
    end
    repeat (rand_bits(4)) begin   // ack delay 0 to 15
      check_value("busy", 32'(busy), 32'(1));
      check_value("mem_req.req", 32'(mem_req[ch].req), 32'(1));
      @(negedge sys_clk);
    end
    if (write) begin
      mem_model[key] = {stage[1], stage[0]};
      word = 16'(rand_bits(16));  // rdata ignored on a write
    end else if (mem_model.exists(key)) begin
      word = mem_model[key];
    end else begin
      word = 16'(rand_bits(16));
      mem_model[key] = word;
    end
    mem_rsp[ch].ack   = 1'b1;
    mem_rsp[ch].rdata = word;
    @(negedge sys_clk);
    mem_rsp[ch] = '0;
    check_value("busy", 32'(busy), 32'(1));
    wait_busy(1'b0);
    if (!write) begin
      read_line(bits);
      check_value("cy_a1_int1 frame", 32'(bits), 32'({1'b0, word, 1'b1}));
    end
  endtask

  task automatic unknown_cmd(input logic [7:0] raw);
    logic [17:0] bits;
    send_frame(raw, 8'(rand_bits(8)));
    wait_busy(1'b1);
    wait_busy(1'b0);
    read_line(bits);
    check_value("cy_a1_int1 frame", 32'(bits), 32'(0));
  endtask

  always @(posedge sys_clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == CYCLE_LIMIT) begin
      $display("run did not finish within %0d cycles", CYCLE_LIMIT);
      stop_run();
    end
  end

  initial begin
    logic [2:0] kind;
    logic [2:0] sel;
    logic [7:0] raw;
    cy_a0_int0 = 1'b0;
    cy_a3_wu2  = 1'b0;
    for (int c = 0; c < `BRIDGE_NUM_CHANNELS; c++) begin
      mem_rsp[c] = '0;
    end
    for (int i = 0; i < 5; i++) begin
      stage[i] = '0;
    end
    @(posedge sys_rst_n);
    @(negedge sys_clk);
    check_value("cy_a1_int1", 32'(cy_a1_int1), 32'(0));
    check_value("busy", 32'(busy), 32'(0));
    for (int c = 0; c < `BRIDGE_NUM_CHANNELS; c++) begin
      check_value($sformatf("mem_req[%0d].req", c), 32'(mem_req[c].req), 32'(0));
    end
    // fill all staging bytes, then write and read back
    for (int i = 0; i < 5; i++) begin
      load_stage(3'(i), 8'(rand_bits(8)));
    end
    mem_access(1'b0, 1'b1);
    mem_access(1'b0, 1'b0);
    mem_access(1'b1, 1'b0);       // unwritten on channel 1
    for (int n = 8; n < NUM_CMDS; n++) begin
      kind = 3'(rand_bits(3));
      if (kind <= 2) begin
        sel = 3'(rand_bits(3));
        if (sel > 4) begin
          sel = sel - 3'd3;
        end
        // small address bytes so reads often hit written words
        load_stage(sel, (sel < 2) ? 8'(rand_bits(8)) : 8'(rand_bits(2)));
      end else if (kind <= 6) begin
        mem_access(1'(rand_bits(1)), kind <= 4);
      end else begin
        raw = 8'(rand_bits(8));
        if (is_known(raw)) begin
          raw = raw ^ 8'h40;
        end
        unknown_cmd(raw);
      end
    end
    $display("TEST PASSED");
    $finish;
  end

endmodule

// File: project.f
+incdir+verilog
verilog/bridge_pkg.sv
verilog/serial_link.sv
verilog/cmd_decoder.sv
verilog/mem_channel.sv
verilog/reply_collector.sv
verilog/usb_bridge_top.sv
verification/tb_clock_gen.sv
verification/bridge_asserts.sv
verification/bridge_tb.sv

// File: run.sh
#!/bin/sh
# build and run the bridge testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/10ps -j 0 \
  --top-module bridge_tb -f project.f -o bridge_sim > build.log 2>&1
if [ $? -ne 0 ]; then
  echo "build failed, see build.log"
  exit 1
fi

./obj_dir/bridge_sim > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -q "^TEST PASSED$" sim.log; then
  exit 0
fi
echo "pass message not found in sim.log"
exit 1
